// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and fetch geometry
`define XLEN         32
`define FETCH_WIDTH  2             // Words returned per memory request

// Instruction buffer
`define IB_DEPTH     8
`define IB_PTR_W     3

// Integer register file
`define NUM_REGS     32

// First fetch address out of reset
`define RESET_PC     32'h1c000000

// Major opcodes, 3R format (bits 31:15)
`define OP_ADD_W     17'h00020
`define OP_SUB_W     17'h00022

// Major opcode, 2RI12 format (bits 31:22)
`define OP_ADDI_W    10'h00a

`endif

// File: cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    // Three-register format, add.w and sub.w
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    // Two registers plus 12-bit signed immediate, addi.w
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;           // Sign extended in execute
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    // One instruction word, seen through either format
    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
    } instr_word_u;

    // Retirement record, mirrors the debug writeback port
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic             wen;
        logic [4:0]       wnum;
        logic [`XLEN-1:0] wdata;
    } commit_t;

endpackage

// File: cpu_ifs.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

// Fetch to instruction buffer, one word pair per valid cycle
interface fetch_bus;
    logic             valid;
    logic [`XLEN-1:0] pc;           // Address of instr0
    logic [`XLEN-1:0] instr0;
    logic [`XLEN-1:0] instr1;
    logic             room;         // Enough space for two pairs

    modport producer (
        output valid, pc, instr0, instr1,
        input  room
    );

    modport buffer (
        input  valid, pc, instr0, instr1,
        output room
    );
endinterface

// Instruction buffer head to execute
interface issue_bus;
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instr;
    logic             take;

    modport buffer (
        output valid, pc, instr,
        input  take
    );

    modport consumer (
        input  valid, pc, instr,
        output take
    );
endinterface

// File: fetch_unit.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             rst,
    output logic [`XLEN-1:0] imem_addr_o,
    output logic             imem_req_o,
    input  logic [`XLEN-1:0] imem_rdata0_i,
    input  logic [`XLEN-1:0] imem_rdata1_i,
    fetch_bus.producer       fb
);

    localparam logic [`XLEN-1:0] PC_STEP = `FETCH_WIDTH * 4;

    logic [`XLEN-1:0] pc_q;
    logic             inflight_q;    // Pair due back this cycle
    logic [`XLEN-1:0] inflight_pc_q;

    // Room already accounts for the pair still in flight
    assign imem_req_o  = fb.room;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q       <= `RESET_PC;
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= imem_req_o;
            if (imem_req_o) begin
                pc_q <= pc_q + PC_STEP;  // Hold PC under back-pressure
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req_o) begin
            inflight_pc_q <= pc_q;
        end
    end

    // Memory answers one cycle after the request
    assign fb.valid  = inflight_q;
    assign fb.pc     = inflight_pc_q;
    assign fb.instr0 = imem_rdata0_i;
    assign fb.instr1 = imem_rdata1_i;

endmodule

// File: instr_buffer.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module instr_buffer (
    input  logic     clk,
    input  logic     rst,
    fetch_bus.buffer fb,
    issue_bus.buffer ib
);

    localparam int DEPTH = `IB_DEPTH;
    localparam int PTR_W = `IB_PTR_W;
    localparam int FW    = `FETCH_WIDTH;

    logic [`XLEN-1:0] pc_mem    [DEPTH];
    logic [`XLEN-1:0] instr_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;       // Occupancy, 0 to DEPTH
    logic [PTR_W:0]   count_d;
    logic             room_q;
    logic             push;
    logic             pop;
    logic [`XLEN-1:0] push_word [FW];

    assign push = fb.valid;          // Never refused, room guards it
    assign pop  = ib.valid & ib.take;

    assign push_word[0] = fb.instr0;
    assign push_word[1] = fb.instr1;

    always_comb begin
        count_d = count_q;
        if (push) begin
            count_d = count_d + (PTR_W + 1)'(FW);
        end
        if (pop) begin
            count_d = count_d - 1'b1;
        end
    end

    // Pair lands in consecutive slots, PCs one word apart
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < FW; i++) begin
                pc_mem[wr_ptr_q + PTR_W'(i)]    <= fb.pc + (i * 4);
                instr_mem[wr_ptr_q + PTR_W'(i)] <= push_word[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            room_q   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(FW);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_d;
            // One pair may be in flight, so ask for space for two
            room_q  <= (DEPTH - int'(count_d)) >= (2 * FW);
        end
    end

    assign fb.room = room_q;

    // Head entry, readable the cycle after its push
    assign ib.valid = (count_q != '0);
    assign ib.pc    = pc_mem[rd_ptr_q];
    assign ib.instr = instr_mem[rd_ptr_q];

endmodule

// File: exec_unit.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module exec_unit (
    input  logic             clk,
    input  logic             rst,
    issue_bus.consumer       ib,
    output logic             commit_valid_o,
    output cpu_pkg::commit_t commit_o
);

    import cpu_pkg::*;

    localparam int REG_W = $clog2(`NUM_REGS);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             take_q;
    logic             pop;
    instr_word_u      iw;
    logic             is_add;
    logic             is_sub;
    logic             is_addi;
    logic [REG_W-1:0] rd;
    logic [`XLEN-1:0] imm_sext;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] result;
    logic             wen;
    commit_t          commit_d;

    // Always ready once out of reset
    assign ib.take = take_q;
    assign pop     = ib.valid & ib.take;

    // Same word decoded as both formats
    assign iw      = ib.instr;
    assign is_add  = (iw.r3.opcode == `OP_ADD_W);
    assign is_sub  = (iw.r3.opcode == `OP_SUB_W);
    assign is_addi = (iw.ri12.opcode == `OP_ADDI_W);

    assign imm_sext = {{(`XLEN - 12){iw.ri12.imm[11]}}, iw.ri12.imm};

    // rj and rd share bit positions across the two formats
    assign rd    = iw.r3.rd;
    assign src_a = regs[iw.r3.rj];
    assign src_b = is_addi ? imm_sext : regs[iw.r3.rk];

    assign result = is_sub ? (src_a - src_b) : (src_a + src_b);  // Wraps mod 2^32

    // Unknown encodings and r0 targets retire without a write
    assign wen = pop & (is_add | is_sub | is_addi) & (rd != '0);

    always_comb begin
        commit_d.pc    = ib.pc;
        commit_d.wen   = wen;
        commit_d.wnum  = wen ? rd : '0;
        commit_d.wdata = wen ? result : '0;
    end

    // Write lands with the commit, visible to the next pop
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[rd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            take_q         <= 1'b0;
            commit_valid_o <= 1'b0;
        end else begin
            take_q         <= 1'b1;
            commit_valid_o <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            commit_o <= commit_d;
        end
    end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu_top (
    input  logic             clk,
    input  logic             rst,

    // Instruction memory, two words per request
    output logic [`XLEN-1:0] imem_addr_o,
    output logic             imem_req_o,
    input  logic [`XLEN-1:0] imem_rdata0_i,
    input  logic [`XLEN-1:0] imem_rdata1_i,

    // Commit debug port
    output logic             commit_valid_o,
    output logic [`XLEN-1:0] commit_pc_o,
    output logic             commit_wen_o,
    output logic [4:0]       commit_wnum_o,
    output logic [`XLEN-1:0] commit_wdata_o
);

    import cpu_pkg::*;

    commit_t commit;

    fetch_bus fb_if ();
    issue_bus ib_if ();

    fetch_unit u_fetch (
        .clk          (clk),
        .rst          (rst),
        .imem_addr_o  (imem_addr_o),
        .imem_req_o   (imem_req_o),
        .imem_rdata0_i(imem_rdata0_i),
        .imem_rdata1_i(imem_rdata1_i),
        .fb           (fb_if.producer)
    );

    instr_buffer u_ibuf (
        .clk(clk),
        .rst(rst),
        .fb (fb_if.buffer),
        .ib (ib_if.buffer)
    );

    exec_unit u_exec (
        .clk           (clk),
        .rst           (rst),
        .ib            (ib_if.consumer),
        .commit_valid_o(commit_valid_o),
        .commit_o      (commit)
    );

    // Record fanned out to the flat debug ports
    assign commit_pc_o    = commit.pc;
    assign commit_wen_o   = commit.wen;
    assign commit_wnum_o  = commit.wnum;
    assign commit_wdata_o = commit.wdata;

endmodule

// File: cpu_props.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu_props (
    input logic              clk,
    input logic              rst,
    input logic [`IB_PTR_W:0] ib_count_i,
    input logic              fb_valid_i,
    input logic              fb_room_i,
    input logic              commit_valid_i,
    input logic              commit_wen_i,
    input logic [4:0]        commit_wnum_i
);

    occupancy_bound: assert property (
        @(posedge clk) disable iff (rst) int'(ib_count_i) <= `IB_DEPTH
    ) else $error("Instruction buffer holds more entries than its depth");

    // A pair lands one cycle after a request made with room high
    push_needs_room: assert property (
        @(posedge clk) disable iff (rst) fb_valid_i |-> $past(fb_room_i)
    ) else $error("Pair pushed although room was low in the request cycle");

    quiet_in_reset: assert property (
        @(posedge clk) $past(rst) |-> !commit_valid_i
    ) else $error("Commit valid high during reset");

    no_r0_write: assert property (
        @(posedge clk) disable iff (rst) (commit_valid_i && commit_wen_i) |-> commit_wnum_i != 5'd0
    ) else $error("Commit writes register zero");

endmodule

bind cpu_top cpu_props u_props (
    .clk           (clk),
    .rst           (rst),
    .ib_count_i    (u_ibuf.count_q),
    .fb_valid_i    (fb_if.valid),
    .fb_room_i     (fb_if.room),
    .commit_valid_i(commit_valid_o),
    .commit_wen_i  (commit_wen_o),
    .commit_wnum_i (commit_wnum_o)
);

// File: tb_checker.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module tb_checker #(
    parameter int PROG_MAX = 512
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        imem_req_i,
    input  logic [31:0] imem_addr_i,
    input  logic        commit_valid_i,
    input  logic [31:0] commit_pc_i,
    input  logic        commit_wen_i,
    input  logic [4:0]  commit_wnum_i,
    input  logic [31:0] commit_wdata_i,
    input  int          test_id_i,
    input  int          expect_count_i,
    output logic        done_o,
    output int          errors_o
);

    import cpu_pkg::*;

    logic [31:0] prog [PROG_MAX];    // Copy of the program under test
    logic [31:0] model_regs [32];
    logic        rst_seen_q;
    logic        first_req;
    logic [31:0] last_req_addr;
    int          expected;
    int          seen;
    int          test_errors;
    int          total_errors = 0;

    assign errors_o = total_errors;

    task automatic load_word(input int idx, input logic [31:0] word);
        prog[idx] = word;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch %s in test %0d at commit %0d: expected %h, got %h",
                 name, test_id_i, seen, exp, act);
        test_errors++;
        total_errors++;
    endtask

    // Applies one word to the model registers, returns the expected record
    function automatic commit_t ref_commit(input logic [31:0] pc, input logic [31:0] word);
        commit_t     rec;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] val;
        logic        writes;
        rd     = word[4:0];
        rj     = word[9:5];
        rk     = word[14:10];
        val    = '0;
        writes = 1'b1;
        if (word[31:15] == `OP_ADD_W) begin
            val = model_regs[rj] + model_regs[rk];
        end else if (word[31:15] == `OP_SUB_W) begin
            val = model_regs[rj] - model_regs[rk];
        end else if (word[31:22] == `OP_ADDI_W) begin
            val = model_regs[rj] + {{20{word[21]}}, word[21:10]};
        end else begin
            writes = 1'b0;                       // Unknown word retires as a no-op
        end
        writes = writes && (rd != 5'd0);
        if (writes) begin
            model_regs[rd] = val;
        end
        rec.pc    = pc;
        rec.wen   = writes;
        rec.wnum  = writes ? rd : 5'd0;
        rec.wdata = writes ? val : '0;
        return rec;
    endfunction

    task automatic check_request();
        logic [31:0] want;
        want = first_req ? `RESET_PC : last_req_addr + 32'd8;
        if (imem_addr_i !== want) begin
            report_mismatch("imem_addr_o", want, imem_addr_i);
        end
        first_req     = 1'b0;
        last_req_addr = imem_addr_i;
    endtask

    task automatic check_commit();
        commit_t exp;
        exp = ref_commit(`RESET_PC + 32'(seen * 4), prog[seen]);
        if (commit_pc_i !== exp.pc) begin
            report_mismatch("commit_pc_o", exp.pc, commit_pc_i);
        end
        if (commit_wen_i !== exp.wen) begin
            report_mismatch("commit_wen_o", 32'(exp.wen), 32'(commit_wen_i));
        end
        if (exp.wen && commit_wnum_i !== exp.wnum) begin
            report_mismatch("commit_wnum_o", 32'(exp.wnum), 32'(commit_wnum_i));
        end
        if (exp.wen && commit_wdata_i !== exp.wdata) begin
            report_mismatch("commit_wdata_o", exp.wdata, commit_wdata_i);
        end
        seen++;
        if (seen == expected) begin
            done_o = 1'b1;
            $display("Test %0d finished: %0d commits, %0d errors",
                     test_id_i, seen, test_errors);
        end
    endtask

    // True once the DUT has seen reset at a clock edge
    always @(posedge clk) begin
        rst_seen_q <= rst;
    end

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (rst) begin
            if (rst_seen_q && (imem_req_i || commit_valid_i)) begin
                $display("Request or commit seen while the core is held in reset");
                test_errors++;
                total_errors++;
            end
            expected    = expect_count_i;
            seen        = 0;
            test_errors = 0;
            done_o      = 1'b0;
            first_req   = 1'b1;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (imem_req_i) begin
                check_request();
            end
            if (commit_valid_i && !done_o) begin
                check_commit();
            end
        end
    end

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module tb_cpu;

    localparam int PROG_MAX     = 512;
    localparam int NUM_TESTS    = 5;
    localparam int RESET_CYCLES = 16;

    localparam logic [31:0] IDLE_WORD = 32'hffffffff;  // Matches no opcode

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic        imem_req;
    logic [31:0] imem_rdata0;
    logic [31:0] imem_rdata1;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_wen;
    logic [4:0]  commit_wnum;
    logic [31:0] commit_wdata;
    logic        chk_done;
    int          chk_errors;
    int          test_id;
    int          expect_count;

    logic [31:0] imem [PROG_MAX];
    logic        req_q;
    logic [31:0] req_addr_q;
    int          prog_len;
    int          tests_run = 0;
    int          cycle_count = 0;
    int          cycle_limit;
    // addi, dependent chain, r0 targets, no-ops, long random mix
    int          test_len [NUM_TESTS] = '{24, 40, 24, 24, 400};

    cpu_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .imem_addr_o   (imem_addr),
        .imem_req_o    (imem_req),
        .imem_rdata0_i (imem_rdata0),
        .imem_rdata1_i (imem_rdata1),
        .commit_valid_o(commit_valid),
        .commit_pc_o   (commit_pc),
        .commit_wen_o  (commit_wen),
        .commit_wnum_o (commit_wnum),
        .commit_wdata_o(commit_wdata)
    );

    tb_checker #(.PROG_MAX(PROG_MAX)) u_chk (
        .clk           (clk),
        .rst           (rst),
        .imem_req_i    (imem_req),
        .imem_addr_i   (imem_addr),
        .commit_valid_i(commit_valid),
        .commit_pc_i   (commit_pc),
        .commit_wen_i  (commit_wen),
        .commit_wnum_i (commit_wnum),
        .commit_wdata_i(commit_wdata),
        .test_id_i     (test_id),
        .expect_count_i(expect_count),
        .done_o        (chk_done),
        .errors_o      (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `RESET_PC) >> 2;
        if (addr >= `RESET_PC && idx < 32'(prog_len)) begin
            return imem[idx];
        end
        return {10'h3ff, addr[21:0] ^ addr[31:10]};  // Matches no opcode past the program end
    endfunction

    // Request and address are stable by the falling edge
    always @(negedge clk) begin
        req_q      = imem_req;
        req_addr_q = imem_addr;
    end

    always @(posedge clk) begin
        #1;
        if (req_q) begin
            imem_rdata0 = mem_word(req_addr_q);
            imem_rdata1 = mem_word(req_addr_q + 32'd4);
        end else begin
            imem_rdata0 = IDLE_WORD;  // Nothing was requested
            imem_rdata1 = IDLE_WORD;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                           input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rj,
                                             input logic [4:0] rd);
        return {`OP_ADDI_W, imm, rj, rd};
    endfunction

    // Word i of a program of the given kind
    function automatic logic [31:0] gen_word(input int kind, input int i);
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  cur;
        logic [4:0]  prev;
        logic [31:0] noop;
        logic [31:0] w;
        imm  = 12'($urandom);
        rd   = 5'($urandom_range(31, 1));
        rj   = 5'($urandom);
        rk   = 5'($urandom);
        cur  = 5'((i % 31) + 1);
        prev = 5'(((i + 30) % 31) + 1);
        noop = {4'hf, 28'($urandom)};  // Top nibble rules out every opcode
        case (kind)
            0: w = enc_addi((i == 0) ? 12'h800 : imm, (i < 3) ? 5'd0 : rj, rd);
            1: w = (i < 2) ? enc_addi(imm, 5'd0, cur) :
                   enc_3r((i % 2 == 1) ? `OP_SUB_W : `OP_ADD_W, rk, prev, cur);
            2: case (i % 4)
                   0: w = enc_addi(imm, rj, 5'd0);
                   1: w = enc_3r(`OP_ADD_W, rk, rj, 5'd0);
                   2: w = enc_3r(`OP_ADD_W, 5'd0, 5'd0, rd);
                   default: w = enc_addi(imm, 5'd0, rd);
               endcase
            3: case (i % 3)
                   0: w = enc_addi(imm, rj, rd);
                   1: w = noop;
                   default: w = enc_3r(`OP_ADD_W, rk, rj, rd);
               endcase
            default: case ($urandom_range(4, 0))
                   0: w = enc_addi(imm, rj, rd);
                   1: w = enc_3r(`OP_ADD_W, rk, rj, rd);
                   2: w = enc_3r(`OP_SUB_W, rk, rj, rd);
                   3: w = noop;
                   default: w = enc_3r(`OP_SUB_W, rk, rj, 5'd0);
               endcase
        endcase
        return w;
    endfunction

    task automatic put_word(input logic [31:0] word);
        imem[prog_len] = word;
        u_chk.load_word(prog_len, word);
        prog_len++;
    endtask

    task automatic run_test(input int t);
        @(posedge clk);
        #1;
        rst          = 1'b1;
        test_id      = t + 1;
        expect_count = test_len[t];
        prog_len     = 0;
        for (int i = 0; i < test_len[t]; i++) begin
            put_word(gen_word(t, i));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        while (!chk_done) begin
            @(posedge clk);
        end
        tests_run++;
    endtask

    initial begin
        void'($urandom(32'he65bd28b));
        rst          = 1'b1;
        imem_rdata0  = '0;
        imem_rdata1  = '0;
        test_id      = 0;
        expect_count = 0;
        cycle_limit  = 0;
        foreach (test_len[t]) begin
            cycle_limit += 40 * test_len[t] + 100;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d of %0d, errors: %0d", tests_run, NUM_TESTS, chk_errors);
        if (chk_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
cpu_pkg.sv
cpu_ifs.sv
fetch_unit.sv
instr_buffer.sv
exec_unit.sv
cpu_top.sv
cpu_props.sv
tb_checker.sv
tb_cpu.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the simulation with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu -f build.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$log"; then
    exit 1
fi
exit 0
